//--- verilog/i2c_cfg.svh
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// Number of command sources sharing the transceiver
`define I2C_NUM_PORTS 2

// clk cycles per quarter of an SCL period
`define I2C_QTR_DIV 4

// Data width of tx and rx bytes
`define I2C_BYTE_BITS 8

`endif

//--- verilog/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// Kinds of bit slot the byte engine hands to the bit driver
	// Start condition, SCL left as it is in the first quarter
	localparam logic [1:0] SLOT_START   = 2'd0;
	// Stop condition, leaves both lines released
	localparam logic [1:0] SLOT_STOP    = 2'd1;
	// Repeated start, SCL pulled low first
	localparam logic [1:0] SLOT_RESTART = 2'd2;
	// One data or ack bit
	localparam logic [1:0] SLOT_BIT     = 2'd3;

	// Round-robin successor
	// Wraps back to port 0 after the last port
	function automatic int unsigned rr_next(
		input int unsigned cur,
		input int unsigned num_ports
	);
		int unsigned nxt;
		nxt = cur + 1;
		if (nxt >= num_ports) begin
			nxt = 0;
		end
		return nxt;
	endfunction

endpackage

`default_nettype wire

//--- verilog/i2c_cmd_if.sv
`default_nettype none

`include "i2c_cfg.svh"

interface i2c_cmd_if;

	// Bus ownership handshake, all one-cycle strobes
	logic request;
	logic done;
	logic ack;

	// Byte-level command strobes, at most one per cycle
	logic start_en;
	logic restart_en;
	logic stop_en;
	logic tx_en;
	logic rx_en;

	// Payload, valid with tx_en or rx_en
	logic [`I2C_BYTE_BITS-1:0] tx_data;
	logic rx_ack;

	// Responses from the engine
	logic busy;
	logic tx_ack;
	logic [`I2C_BYTE_BITS-1:0] rx_out;

	// Outside command source
	modport driver (
		output request, done, start_en, restart_en, stop_en, tx_en, rx_en, tx_data, rx_ack,
		input ack, busy, tx_ack, rx_out
	);

	// Arbiter, one per source
	modport arb_port (
		input request, done, start_en, restart_en, stop_en, tx_en, rx_en, tx_data, rx_ack,
		output ack, busy, tx_ack, rx_out
	);

	// Arbiter, single side toward the engine
	modport arb_txvr (
		output start_en, restart_en, stop_en, tx_en, rx_en, tx_data, rx_ack,
		input busy, tx_ack, rx_out
	);

	modport engine (
		input start_en, restart_en, stop_en, tx_en, rx_en, tx_data, rx_ack,
		output busy, tx_ack, rx_out
	);

endinterface

`default_nettype wire

//--- verilog/i2c_port_arbiter.sv
`default_nettype none

`include "i2c_cfg.svh"

module i2c_port_arbiter
	import i2c_pkg::*;
#(
	parameter int NUM_PORTS = 2
) (
	input logic clk,
	input logic arst_n,
	i2c_cmd_if.arb_port ports [NUM_PORTS],
	i2c_cmd_if.arb_txvr txvr
);

	localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
	localparam int BITS = `I2C_BYTE_BITS;

	// Flattened per-port command inputs
	logic [NUM_PORTS-1:0] req_vec;
	logic [NUM_PORTS-1:0] done_vec;
	logic [NUM_PORTS-1:0] start_vec;
	logic [NUM_PORTS-1:0] restart_vec;
	logic [NUM_PORTS-1:0] stop_vec;
	logic [NUM_PORTS-1:0] tx_vec;
	logic [NUM_PORTS-1:0] rx_vec;
	logic [NUM_PORTS-1:0] rx_ack_vec;
	logic [BITS-1:0] tx_data_arr [NUM_PORTS];

	// Arbitration state
	logic [NUM_PORTS-1:0] pending;
	logic [NUM_PORTS-1:0] ack_q;
	logic [NUM_PORTS-1:0] sel_hit;
	logic [NUM_PORTS-1:0] sel_mask;
	logic active;
	logic [PORT_BITS-1:0] sel;
	logic [PORT_BITS-1:0] rr_ptr;
	logic grant_any;
	logic [PORT_BITS-1:0] grant_idx;

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
		assign req_vec[g] = ports[g].request;
		assign done_vec[g] = ports[g].done;
		assign start_vec[g] = ports[g].start_en;
		assign restart_vec[g] = ports[g].restart_en;
		assign stop_vec[g] = ports[g].stop_en;
		assign tx_vec[g] = ports[g].tx_en;
		assign rx_vec[g] = ports[g].rx_en;
		assign rx_ack_vec[g] = ports[g].rx_ack;
		assign tx_data_arr[g] = ports[g].tx_data;

		// Responses only reach the granted port, others read zero
		assign sel_hit[g] = active && (sel == PORT_BITS'(g));
		assign ports[g].ack = ack_q[g];
		assign ports[g].busy = sel_hit[g] & txvr.busy;
		assign ports[g].tx_ack = sel_hit[g] & txvr.tx_ack;
		assign ports[g].rx_out = sel_hit[g] ? txvr.rx_out : '0;
	end

	// Commands of the granted port go to the engine
	assign txvr.start_en = active & start_vec[sel];
	assign txvr.restart_en = active & restart_vec[sel];
	assign txvr.stop_en = active & stop_vec[sel];
	assign txvr.tx_en = active & tx_vec[sel];
	assign txvr.rx_en = active & rx_vec[sel];
	assign txvr.rx_ack = active & rx_ack_vec[sel];
	assign txvr.tx_data = tx_data_arr[sel];

	assign sel_mask = NUM_PORTS'(1) << sel;

	// Pointer port first, else the lowest pending port
	always_comb begin
		grant_any = |pending;
		grant_idx = rr_ptr;
		if (!pending[rr_ptr]) begin
			for (int i = NUM_PORTS - 1; i >= 0; i--) begin
				if (pending[i]) begin
					grant_idx = PORT_BITS'(i);
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= '0;
			ack_q <= '0;
			active <= 1'b0;
			sel <= '0;
			rr_ptr <= '0;
		end else begin
			ack_q <= '0;
			if (active && done_vec[sel]) begin
				// Release the bus, next grant no earlier than the following edge
				active <= 1'b0;
				pending <= (pending | req_vec) & ~sel_mask;
				rr_ptr <= PORT_BITS'(rr_next(32'(rr_ptr), NUM_PORTS));
			end else begin
				// New requests only count from the next edge on
				pending <= pending | req_vec;
				if (!active && grant_any) begin
					active <= 1'b1;
					sel <= grant_idx;
					ack_q[grant_idx] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/i2c_byte_engine.sv
`default_nettype none

`include "i2c_cfg.svh"

module i2c_byte_engine
	import i2c_pkg::*;
(
	input logic clk,
	input logic arst_n,
	i2c_cmd_if.engine cmd,
	output logic slot_go,
	output logic [1:0] slot_kind,
	output logic slot_sda,
	input logic slot_busy,
	input logic slot_sda_in
);

	localparam int BITS = `I2C_BYTE_BITS;
	localparam int CNT_W = $clog2(BITS + 1);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_GO = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;

	// What the current command is made of
	localparam logic [1:0] OP_CTRL = 2'd0;
	localparam logic [1:0] OP_TX = 2'd1;
	localparam logic [1:0] OP_RX = 2'd2;

	logic [1:0] state;
	logic [1:0] op_q;
	logic [CNT_W-1:0] bit_cnt;
	logic busy_q;
	logic tx_ack_q;
	logic ack_bit_q;
	logic any_en;
	logic slot_done;
	logic last_slot;
	logic [BITS-1:0] shift_q;
	logic [BITS-1:0] rx_q;

	assign any_en = cmd.start_en | cmd.restart_en | cmd.stop_en | cmd.tx_en | cmd.rx_en;
	assign slot_done = (state == ST_WAIT) && !slot_busy;
	// Control ops have one slot, bytes end after the ninth
	assign last_slot = (op_q == OP_CTRL) || (bit_cnt == CNT_W'(BITS));

	// Driver latches the slot while the engine sits in ST_GO
	assign slot_go = (state == ST_GO);

	assign cmd.busy = busy_q;
	assign cmd.tx_ack = tx_ack_q;
	assign cmd.rx_out = rx_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			op_q <= OP_CTRL;
			bit_cnt <= '0;
			busy_q <= 1'b0;
			tx_ack_q <= 1'b0;
			ack_bit_q <= 1'b0;
			slot_kind <= SLOT_BIT;
			slot_sda <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					if (any_en) begin
						busy_q <= 1'b1;
						state <= ST_GO;
						bit_cnt <= '0;
						op_q <= OP_CTRL;
						slot_sda <= 1'b1;
						if (cmd.start_en) begin
							slot_kind <= SLOT_START;
						end else if (cmd.restart_en) begin
							slot_kind <= SLOT_RESTART;
						end else if (cmd.stop_en) begin
							slot_kind <= SLOT_STOP;
						end else if (cmd.tx_en) begin
							// MSB goes out first
							op_q <= OP_TX;
							slot_kind <= SLOT_BIT;
							slot_sda <= cmd.tx_data[BITS-1];
						end else begin
							op_q <= OP_RX;
							slot_kind <= SLOT_BIT;
							ack_bit_q <= cmd.rx_ack;
						end
					end
				end
				ST_GO: begin
					state <= ST_WAIT;
				end
				ST_WAIT: begin
					if (slot_done && last_slot) begin
						state <= ST_IDLE;
						busy_q <= 1'b0;
						// Slave pulled SDA low in the ack slot
						if (op_q == OP_TX) begin
							tx_ack_q <= ~slot_sda_in;
						end
					end else if (slot_done) begin
						state <= ST_GO;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(BITS - 1)) begin
							// Ack slot, released for tx, driven for rx
							slot_sda <= (op_q == OP_TX) ? 1'b1 : ~ack_bit_q;
						end else begin
							slot_sda <= (op_q == OP_TX) ? shift_q[BITS-2] : 1'b1;
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Shared shifter, tx bits move out and rx samples move in
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && cmd.tx_en) begin
			shift_q <= cmd.tx_data;
		end else if (slot_done && !last_slot && op_q == OP_TX) begin
			shift_q <= {shift_q[BITS-2:0], 1'b0};
		end else if (slot_done && !last_slot && op_q == OP_RX) begin
			shift_q <= {shift_q[BITS-2:0], slot_sda_in};
		end
		if (slot_done && op_q == OP_RX && bit_cnt == CNT_W'(BITS)) begin
			rx_q <= shift_q;
		end
	end

endmodule

`default_nettype wire

//--- verilog/i2c_bit_driver.sv
`default_nettype none

`include "i2c_cfg.svh"

module i2c_bit_driver
	import i2c_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic slot_go,
	input logic [1:0] slot_kind,
	input logic slot_sda,
	output logic slot_busy,
	output logic slot_sda_in,
	output logic scl_oe,
	output logic sda_oe,
	input logic scl_in,
	input logic sda_in
);

	localparam int DIV_W = (`I2C_QTR_DIV > 1) ? $clog2(`I2C_QTR_DIV) : 1;

	logic [DIV_W-1:0] div_q;
	logic [1:0] phase_q;
	logic [1:0] kind_q;
	logic sda_q;
	logic sampled_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_busy <= 1'b0;
			slot_sda_in <= 1'b1;
			scl_oe <= 1'b0;
			sda_oe <= 1'b0;
			div_q <= '0;
			phase_q <= '0;
			kind_q <= SLOT_BIT;
			sda_q <= 1'b1;
			sampled_q <= 1'b0;
		end else if (!slot_busy) begin
			if (slot_go) begin
				slot_busy <= 1'b1;
				kind_q <= slot_kind;
				sda_q <= slot_sda;
				div_q <= '0;
				phase_q <= '0;
				sampled_q <= 1'b0;
			end
		end else begin
			// Quarter 0 sets SDA, quarters 1 and 2 hold SCL high, quarter 3 drops it
			case (phase_q)
				2'd0: begin
					if (kind_q == SLOT_BIT) begin
						scl_oe <= 1'b1;
						sda_oe <= ~sda_q;
					end else if (kind_q == SLOT_STOP) begin
						scl_oe <= 1'b1;
						sda_oe <= 1'b1;
					end else begin
						// Start from idle keeps SCL high, restart pulls it low first
						scl_oe <= (kind_q == SLOT_RESTART) | scl_oe;
						sda_oe <= 1'b0;
					end
				end
				2'd1: scl_oe <= 1'b0;
				2'd2: begin
					// SDA edge with SCL high marks start or stop
					if (kind_q == SLOT_START || kind_q == SLOT_RESTART) begin
						sda_oe <= 1'b1;
					end else if (kind_q == SLOT_STOP) begin
						sda_oe <= 1'b0;
					end
				end
				default: scl_oe <= (kind_q != SLOT_STOP);
			endcase
			// Sample once SCL actually reads high
			if ((phase_q == 2'd1 || phase_q == 2'd2) && scl_in && !sampled_q) begin
				slot_sda_in <= sda_in;
				sampled_q <= 1'b1;
			end
			if (div_q == DIV_W'(`I2C_QTR_DIV - 1)) begin
				div_q <= '0;
				phase_q <= phase_q + 1'b1;
				slot_busy <= (phase_q != 2'd3);
			end else begin
				div_q <= div_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/i2c_mux_top.sv
`default_nettype none

`include "i2c_cfg.svh"

module i2c_mux_top (
	input logic clk,
	input logic arst_n,
	input logic [`I2C_NUM_PORTS-1:0] request,
	input logic [`I2C_NUM_PORTS-1:0] done,
	output logic [`I2C_NUM_PORTS-1:0] ack,
	input logic [`I2C_NUM_PORTS-1:0] start_en,
	input logic [`I2C_NUM_PORTS-1:0] restart_en,
	input logic [`I2C_NUM_PORTS-1:0] stop_en,
	input logic [`I2C_NUM_PORTS-1:0] tx_en,
	input logic [`I2C_NUM_PORTS*`I2C_BYTE_BITS-1:0] tx_data,
	input logic [`I2C_NUM_PORTS-1:0] rx_en,
	input logic [`I2C_NUM_PORTS-1:0] rx_ack,
	output logic [`I2C_NUM_PORTS-1:0] busy,
	output logic [`I2C_NUM_PORTS-1:0] tx_ack,
	output logic [`I2C_NUM_PORTS*`I2C_BYTE_BITS-1:0] rx_out,
	// Open drain pins, oe high pulls the line low
	output logic scl_oe,
	output logic sda_oe,
	input logic scl_in,
	input logic sda_in
);

	localparam int NP = `I2C_NUM_PORTS;
	localparam int BITS = `I2C_BYTE_BITS;

	logic slot_go;
	logic [1:0] slot_kind;
	logic slot_sda;
	logic slot_busy;
	logic slot_sda_in;

	i2c_cmd_if port_if [NP] ();
	i2c_cmd_if eng_if ();

	// Flat vectors onto one bundle per source
	for (genvar g = 0; g < NP; g++) begin : g_port
		assign port_if[g].request = request[g];
		assign port_if[g].done = done[g];
		assign port_if[g].start_en = start_en[g];
		assign port_if[g].restart_en = restart_en[g];
		assign port_if[g].stop_en = stop_en[g];
		assign port_if[g].tx_en = tx_en[g];
		assign port_if[g].tx_data = tx_data[g*BITS +: BITS];
		assign port_if[g].rx_en = rx_en[g];
		assign port_if[g].rx_ack = rx_ack[g];
		assign ack[g] = port_if[g].ack;
		assign busy[g] = port_if[g].busy;
		assign tx_ack[g] = port_if[g].tx_ack;
		assign rx_out[g*BITS +: BITS] = port_if[g].rx_out;
	end

	// Engine bundle carries no ownership handshake
	assign eng_if.request = 1'b0;
	assign eng_if.done = 1'b0;
	assign eng_if.ack = 1'b0;

	i2c_port_arbiter #(
		.NUM_PORTS(NP)
	) arb_i (
		.clk(clk),
		.arst_n(arst_n),
		.ports(port_if),
		.txvr(eng_if)
	);

	i2c_byte_engine eng_i (
		.clk(clk),
		.arst_n(arst_n),
		.cmd(eng_if),
		.slot_go(slot_go),
		.slot_kind(slot_kind),
		.slot_sda(slot_sda),
		.slot_busy(slot_busy),
		.slot_sda_in(slot_sda_in)
	);

	i2c_bit_driver drv_i (
		.clk(clk),
		.arst_n(arst_n),
		.slot_go(slot_go),
		.slot_kind(slot_kind),
		.slot_sda(slot_sda),
		.slot_busy(slot_busy),
		.slot_sda_in(slot_sda_in),
		.scl_oe(scl_oe),
		.sda_oe(sda_oe),
		.scl_in(scl_in),
		.sda_in(sda_in)
	);

endmodule

`default_nettype wire

//--- dv/i2c_mux_assert.sv
`default_nettype none

`include "i2c_cfg.svh"

module i2c_mux_assert
	import i2c_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic [`I2C_NUM_PORTS-1:0] ack,
	input logic [`I2C_NUM_PORTS-1:0] done,
	input logic [`I2C_NUM_PORTS-1:0] busy,
	input logic scl_in,
	input logic sda_in,
	input logic [1:0] slot_kind
);

	// Ports that currently own the bus, from ack until done
	logic [`I2C_NUM_PORTS-1:0] owned;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			owned <= '0;
		end else begin
			owned <= (owned | ack) & ~done;
		end
	end

	// At most one grant strobe at a time
	ack_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(ack))
		else $error("ack is not one-hot or zero");

	// Engine responses only reach the owner
	busy_owned: assert property (@(posedge clk) disable iff (!arst_n)
		((busy & ~owned) == '0))
		else $error("busy seen on a port without the bus");

	// SDA edge with SCL high belongs to a start or stop slot
	sda_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(scl_in && $past(scl_in) && (sda_in != $past(sda_in))) |-> (slot_kind != SLOT_BIT))
		else $error("SDA moved while SCL was high in a data slot");

endmodule

bind i2c_mux_top i2c_mux_assert assert_i (
	.clk(clk),
	.arst_n(arst_n),
	.ack(ack),
	.done(done),
	.busy(busy),
	.scl_in(scl_in),
	.sda_in(sda_in),
	.slot_kind(slot_kind)
);

`default_nettype wire

//--- dv/i2c_mux_tb.sv
`default_nettype none

`include "i2c_cfg.svh"

module i2c_mux_tb;

	localparam int NP = `I2C_NUM_PORTS;
	localparam int BITS = `I2C_BYTE_BITS;
	// Write, read, blocked check and three rounds of two writes
	localparam int NUM_TRANS = 9;
	localparam int TIMEOUT_CYCLES = NUM_TRANS * 20 * 4 * `I2C_QTR_DIV + 500;

	localparam int CMD_START = 0;
	localparam int CMD_STOP = 1;
	localparam int CMD_TX = 2;
	localparam int CMD_RX = 3;

	logic clk;
	logic arst_n;
	logic [NP-1:0] request;
	logic [NP-1:0] done;
	logic [NP-1:0] ack;
	logic [NP-1:0] start_en;
	logic [NP-1:0] restart_en;
	logic [NP-1:0] stop_en;
	logic [NP-1:0] tx_en;
	logic [NP*BITS-1:0] tx_data;
	logic [NP-1:0] rx_en;
	logic [NP-1:0] rx_ack;
	logic [NP-1:0] busy;
	logic [NP-1:0] tx_ack;
	logic [NP*BITS-1:0] rx_out;
	logic scl_oe;
	logic sda_oe;
	wire scl_in;
	wire sda_in;

	// Slave model state
	logic slave_pull = 1'b0;
	logic slave_read = 1'b0;
	logic nack_end = 1'b0;
	logic scl_prev = 1'b1;
	logic sda_prev = 1'b1;
	int slave_cnt = 0;
	logic [BITS-1:0] slave_shift = '0;
	logic [BITS-1:0] slave_last = '0;

	// Bytes handed to the DUT and bytes the slave decoded
	logic [BITS-1:0] sent_q [$];
	logic [BITS-1:0] seen_q [$];

	// Arbiter model
	logic [NP-1:0] pend_m = '0;
	int rr_ptr_m = 0;

	logic [31:0] lcg_state = 32'h42f8_6547;
	logic [BITS-1:0] last_written = '0;
	int cycle_cnt = 0;
	int err_cnt = 0;

	// Open drain lines with pull-ups
	assign scl_in = ~scl_oe;
	assign sda_in = ~(sda_oe | slave_pull);

	i2c_mux_top dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.request(request),
		.done(done),
		.ack(ack),
		.start_en(start_en),
		.restart_en(restart_en),
		.stop_en(stop_en),
		.tx_en(tx_en),
		.tx_data(tx_data),
		.rx_en(rx_en),
		.rx_ack(rx_ack),
		.busy(busy),
		.tx_ack(tx_ack),
		.rx_out(rx_out),
		.scl_oe(scl_oe),
		.sda_oe(sda_oe),
		.scl_in(scl_in),
		.sda_in(sda_in)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Slave answers a read with the inverse of the last byte written
	function automatic logic [BITS-1:0] expected_read(input logic [BITS-1:0] written);
		return ~written;
	endfunction

	// Pointer port if pending, else the lowest pending port
	function automatic int grant_pick(input logic [NP-1:0] pend, input int ptr);
		if (pend[ptr]) begin
			return ptr;
		end
		for (int i = 0; i < NP; i++) begin
			if (pend[i]) begin
				return i;
			end
		end
		return ptr;
	endfunction

	task automatic report_failure();
		err_cnt++;
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input logic [BITS-1:0] exp,
		input logic [BITS-1:0] got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: expected %b, got %b", $time, name, exp, got);
			report_failure();
		end
	endtask

	task automatic check_grant(input string name, input logic [NP-1:0] exp,
		input logic [NP-1:0] got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: expected %b, got %b", $time, name, exp, got);
			report_failure();
		end
	endtask

	task automatic request_ports(input logic [NP-1:0] mask);
		@(posedge clk);
		request <= mask;
		@(posedge clk);
		request <= '0;
		pend_m = pend_m | mask;
	endtask

	// Wait for any ack and compare it with the round-robin model
	task automatic wait_grant(output int p);
		int exp;
		do @(negedge clk); while (ack == '0);
		exp = grant_pick(pend_m, rr_ptr_m);
		check_grant("ack", NP'(1) << exp, ack);
		p = exp;
	endtask

	task automatic release_port(input int p);
		@(posedge clk);
		done[p] <= 1'b1;
		@(posedge clk);
		done[p] <= 1'b0;
		pend_m[p] = 1'b0;
		rr_ptr_m = (rr_ptr_m + 1) % NP;
	endtask

	task automatic pulse_cmd(input int p, input int cmd, input logic [BITS-1:0] data,
		input logic ack_bit);
		@(posedge clk);
		case (cmd)
			CMD_START: start_en[p] <= 1'b1;
			CMD_STOP: stop_en[p] <= 1'b1;
			CMD_TX: begin
				tx_en[p] <= 1'b1;
				tx_data[p*BITS +: BITS] <= data;
			end
			default: begin
				rx_en[p] <= 1'b1;
				rx_ack[p] <= ack_bit;
			end
		endcase
		@(posedge clk);
		start_en <= '0;
		stop_en <= '0;
		tx_en <= '0;
		rx_en <= '0;
	endtask

	// Strobe, then wait for busy to rise and fall
	task automatic run_cmd(input int p, input int cmd, input logic [BITS-1:0] data,
		input logic ack_bit);
		pulse_cmd(p, cmd, data, ack_bit);
		do @(negedge clk); while (!busy[p]);
		do @(negedge clk); while (busy[p]);
	endtask

	task automatic write_txn(input int p, input logic [BITS-1:0] data);
		run_cmd(p, CMD_START, '0, 1'b0);
		sent_q.push_back(data);
		run_cmd(p, CMD_TX, data, 1'b0);
		check_bit("tx_ack", 1'b1, tx_ack[p]);
		run_cmd(p, CMD_STOP, '0, 1'b0);
		last_written = data;
	endtask

	// Single byte read ended by a NACK
	task automatic read_txn(input int p);
		slave_read = 1'b1;
		run_cmd(p, CMD_START, '0, 1'b0);
		run_cmd(p, CMD_RX, '0, 1'b0);
		check_byte("rx_out", expected_read(last_written), rx_out[p*BITS +: BITS]);
		// rx_ack low leaves SDA released in the ack slot
		check_bit("nack_end", 1'b1, nack_end);
		slave_read = 1'b0;
		run_cmd(p, CMD_STOP, '0, 1'b0);
	endtask

	// Slave model, decodes SCL edges and start or stop conditions
	always @(scl_in or sda_in) begin
		if (scl_in && !scl_prev) begin
			if (slave_cnt < BITS) begin
				if (!slave_read) begin
					slave_shift = {slave_shift[BITS-2:0], sda_in};
				end
				slave_cnt++;
				if (slave_cnt == BITS && !slave_read) begin
					slave_last = slave_shift;
					seen_q.push_back(slave_shift);
				end
			end else begin
				// NACK from the master ends the read
				if (slave_read && sda_in) begin
					nack_end = 1'b1;
				end
				slave_cnt = 0;
			end
		end else if (!scl_in && scl_prev) begin
			if (slave_read && !nack_end && slave_cnt < BITS) begin
				// Pull low where the inverse bit is zero
				slave_pull = slave_last[BITS-1-slave_cnt];
			end else begin
				slave_pull = !slave_read && (slave_cnt == BITS);
			end
		end else if (scl_in && (sda_in != sda_prev)) begin
			slave_cnt = 0;
			nack_end = 1'b0;
		end
		scl_prev = scl_in;
		sda_prev = sda_in;
	end

	// Bytes on the bus against bytes sent
	always @(posedge clk) begin
		if (sent_q.size() > 0 && seen_q.size() > 0) begin
			check_byte("slave_byte", sent_q.pop_front(), seen_q.pop_front());
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles without finishing the tests", cycle_cnt);
			report_failure();
		end
	end

	initial begin
		int p;
		int other;
		logic [BITS-1:0] data;
		arst_n = 1'b0;
		request = '0;
		done = '0;
		start_en = '0;
		restart_en = '0;
		stop_en = '0;
		tx_en = '0;
		tx_data = '0;
		rx_en = '0;
		rx_ack = '0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		// Bus released and arbiter idle after reset
		@(negedge clk);
		check_bit("scl_oe", 1'b0, scl_oe);
		check_bit("sda_oe", 1'b0, sda_oe);
		check_grant("ack", '0, ack);
		check_grant("busy", '0, busy);

		// Write from port 0
		request_ports(NP'(1));
		wait_grant(p);
		lcg_state = lcg_next(lcg_state);
		data = lcg_state[23:16];
		write_txn(p, data);
		release_port(p);

		// Read back through port 1
		request_ports(NP'(2));
		wait_grant(p);
		read_txn(p);
		release_port(p);

		// Commands from the other port are dropped
		// Pointer sits on port 0 here, so port 1 wins as the lowest pending port
		request_ports(NP'(2));
		wait_grant(p);
		other = (p + 1) % NP;
		pulse_cmd(other, CMD_START, '0, 1'b0);
		pulse_cmd(other, CMD_TX, 8'h5a, 1'b0);
		repeat (4 * 4 * `I2C_QTR_DIV) begin
			@(negedge clk);
			check_bit("scl_oe", 1'b0, scl_oe);
			check_bit("sda_oe", 1'b0, sda_oe);
			check_grant("busy", '0, busy);
		end
		release_port(p);

		// Same-cycle requests, order from the round-robin model
		repeat (3) begin
			request_ports('1);
			repeat (NP) begin
				wait_grant(p);
				lcg_state = lcg_next(lcg_state);
				data = lcg_state[23:16];
				write_txn(p, data);
				release_port(p);
			end
		end

		repeat (10) @(negedge clk);
		if (sent_q.size() != 0) begin
			$display("Slave model never decoded %0d of the written bytes", sent_q.size());
			report_failure();
		end
		if (seen_q.size() != 0) begin
			$display("Slave model decoded %0d bytes that were never written", seen_q.size());
			report_failure();
		end
		if (err_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- i2c_mux.f
+incdir+verilog
verilog/i2c_pkg.sv
verilog/i2c_cmd_if.sv
verilog/i2c_port_arbiter.sv
verilog/i2c_byte_engine.sv
verilog/i2c_bit_driver.sv
verilog/i2c_mux_top.sv
dv/i2c_mux_assert.sv
dv/i2c_mux_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the i2c_mux testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module i2c_mux_tb \
	-f i2c_mux.f \
	-o i2c_mux_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/i2c_mux_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
exit 0
